/* rtl/cp0_pkg.sv */
package cp0_pkg;

    typedef logic [31:0] word_t;

    // CP0 register select, register number times eight
    localparam logic [7:0] badvaddr_idx = 8'h40;
    localparam logic [7:0] count_idx    = 8'h48;
    localparam logic [7:0] compare_idx  = 8'h58;
    localparam logic [7:0] status_idx   = 8'h60;
    localparam logic [7:0] cause_idx    = 8'h68;
    localparam logic [7:0] epc_idx      = 8'h70;

    // Cause.ExcCode values
    localparam logic [4:0] exc_int  = 5'd0;
    localparam logic [4:0] exc_adel = 5'd4;   // Load or fetch address error
    localparam logic [4:0] exc_ades = 5'd5;   // Store address error
    localparam logic [4:0] exc_sys  = 5'd8;
    localparam logic [4:0] exc_bp   = 5'd9;
    localparam logic [4:0] exc_ri   = 5'd10;

    // Operation class handed over by decode.
    // op_rsvd stands for an encoding with no defined meaning
    typedef enum logic [3:0] {
        op_none    = 4'd0,
        op_lw      = 4'd1,
        op_sw      = 4'd2,
        op_syscall = 4'd3,
        op_break   = 4'd4,
        op_eret    = 4'd5,
        op_mtc0    = 4'd6,
        op_mfc0    = 4'd7,
        op_rsvd    = 4'd8
    } op_t;

    // Exception entry with BEV=1
    localparam word_t exc_vector = 32'hBFC0_0380;

    // Status bit positions
    localparam int unsigned st_ie  = 0;
    localparam int unsigned st_exl = 1;
    localparam int unsigned st_bev = 22;

    // Cause bit positions
    localparam int unsigned ca_ti = 30;
    localparam int unsigned ca_bd = 31;

endpackage

/* rtl/exc_detect.sv */
`timescale 1ns/1ps

module exc_detect (
    input  logic            ex_valid,
    input  cp0_pkg::op_t    ex_op,
    input  cp0_pkg::word_t  ex_pc,
    input  cp0_pkg::word_t  ex_mem_addr,
    input  logic            interrupt,
    output logic            det_exc,
    output logic [4:0]      det_exccode,
    output cp0_pkg::word_t  det_badvaddr
);

    logic pc_misaligned;
    logic addr_misaligned;

    assign pc_misaligned   = (ex_pc[1:0] != 2'b00);
    assign addr_misaligned = (ex_mem_addr[1:0] != 2'b00);   // Word accesses only

    // Fetch fault reports the PC, otherwise the data address
    assign det_badvaddr = pc_misaligned ? ex_pc : ex_mem_addr;

    always_comb begin
        det_exc     = 1'b0;
        det_exccode = cp0_pkg::exc_int;

        if (!ex_valid) begin
            det_exc = 1'b0;
        end else if (interrupt) begin
            // Pending interrupt rides on whatever instruction is here
            det_exc     = 1'b1;
            det_exccode = cp0_pkg::exc_int;
        end else if (pc_misaligned) begin
            det_exc     = 1'b1;
            det_exccode = cp0_pkg::exc_adel;
        end else begin
            case (ex_op)
                cp0_pkg::op_lw: begin
                    det_exc     = addr_misaligned;
                    det_exccode = cp0_pkg::exc_adel;
                end
                cp0_pkg::op_sw: begin
                    det_exc     = addr_misaligned;
                    det_exccode = cp0_pkg::exc_ades;
                end
                cp0_pkg::op_syscall: begin
                    det_exc     = 1'b1;
                    det_exccode = cp0_pkg::exc_sys;
                end
                cp0_pkg::op_break: begin
                    det_exc     = 1'b1;
                    det_exccode = cp0_pkg::exc_bp;
                end
                cp0_pkg::op_none,
                cp0_pkg::op_eret,
                cp0_pkg::op_mtc0,
                cp0_pkg::op_mfc0: begin
                    det_exc = 1'b0;
                end
                default: begin
                    // Anything undefined traps as reserved
                    det_exc     = 1'b1;
                    det_exccode = cp0_pkg::exc_ri;
                end
            endcase
        end
    end

endmodule

/* rtl/exc_stage_reg.sv */
`timescale 1ns/1ps

module exc_stage_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  logic            ex_valid,
    input  cp0_pkg::op_t    ex_op,
    input  cp0_pkg::word_t  ex_pc,
    input  logic            ex_bd,
    input  logic [7:0]      ex_cp0_addr,
    input  cp0_pkg::word_t  ex_wdata,
    input  logic            det_exc,
    input  logic [4:0]      det_exccode,
    input  cp0_pkg::word_t  det_badvaddr,
    output logic            mem_valid,
    output cp0_pkg::op_t    mem_op,
    output cp0_pkg::word_t  mem_pc,
    output logic            mem_bd,
    output logic [7:0]      mem_cp0_addr,
    output cp0_pkg::word_t  mem_wdata,
    output logic            mem_exc,
    output logic [4:0]      mem_exccode,
    output cp0_pkg::word_t  mem_badvaddr
);

    // Valid bit, dropped when the memory stage redirects
    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            mem_valid <= 1'b0;   // Squash the younger instruction
        end else begin
            mem_valid <= ex_valid;
        end
    end

    // Payload follows execute every cycle, meaningful only with mem_valid
    always_ff @(posedge clk) begin
        mem_op       <= ex_op;
        mem_pc       <= ex_pc;
        mem_bd       <= ex_bd;
        mem_cp0_addr <= ex_cp0_addr;
        mem_wdata    <= ex_wdata;
        mem_exc      <= det_exc;
        mem_exccode  <= det_exccode;
        mem_badvaddr <= det_badvaddr;
    end

endmodule

/* rtl/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_valid,
    input  cp0_pkg::op_t    mem_op,
    input  cp0_pkg::word_t  mem_pc,
    input  logic            mem_bd,
    input  logic [7:0]      mem_cp0_addr,
    input  cp0_pkg::word_t  mem_wdata,
    input  logic            mem_exc,
    input  logic [4:0]      mem_exccode,
    input  cp0_pkg::word_t  mem_badvaddr,
    input  logic [5:0]      ext_int_in,
    output cp0_pkg::word_t  rdata,
    output cp0_pkg::word_t  epc,
    output logic            interrupt
);

    cp0_pkg::word_t badvaddr;
    cp0_pkg::word_t count;
    cp0_pkg::word_t compare;
    logic           tick;        // Half-rate enable for Count

    logic [7:0]     st_im;
    logic           st_exl;
    logic           st_ie;

    logic           ca_bd;
    logic           ca_ti;
    logic [5:0]     ca_ip_hw;    // IP7..IP2
    logic [1:0]     ca_ip_sw;    // IP1..IP0
    logic [4:0]     ca_exccode;

    cp0_pkg::word_t status_word;
    cp0_pkg::word_t cause_word;

    logic take_exc;
    logic do_eret;
    logic do_mtc0;
    logic wr_badvaddr;
    logic wr_count;
    logic wr_compare;
    logic wr_status;
    logic wr_cause;
    logic wr_epc;
    logic addr_fault;

    // Exception beats ERET and MTC0 on the same instruction
    assign take_exc = mem_valid && mem_exc;
    assign do_eret  = mem_valid && !mem_exc && (mem_op == cp0_pkg::op_eret);
    assign do_mtc0  = mem_valid && !mem_exc && (mem_op == cp0_pkg::op_mtc0);

    assign wr_badvaddr = do_mtc0 && (mem_cp0_addr == cp0_pkg::badvaddr_idx);
    assign wr_count    = do_mtc0 && (mem_cp0_addr == cp0_pkg::count_idx);
    assign wr_compare  = do_mtc0 && (mem_cp0_addr == cp0_pkg::compare_idx);
    assign wr_status   = do_mtc0 && (mem_cp0_addr == cp0_pkg::status_idx);
    assign wr_cause    = do_mtc0 && (mem_cp0_addr == cp0_pkg::cause_idx);
    assign wr_epc      = do_mtc0 && (mem_cp0_addr == cp0_pkg::epc_idx);

    assign addr_fault = (mem_exccode == cp0_pkg::exc_adel) ||
                        (mem_exccode == cp0_pkg::exc_ades);

    always_ff @(posedge clk) begin
        if (take_exc && addr_fault) begin
            badvaddr <= mem_badvaddr;
        end else if (wr_badvaddr) begin
            badvaddr <= mem_wdata;
        end
    end

    // Count steps on every other clock
    always_ff @(posedge clk) begin
        if (!rst) begin
            tick  <= 1'b0;
            count <= '0;
        end else begin
            tick <= ~tick;
            if (wr_count) begin
                count <= mem_wdata;
            end else if (tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_compare) begin
            compare <= mem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            st_im  <= '0;
            st_exl <= 1'b0;
            st_ie  <= 1'b0;
        end else if (take_exc) begin
            st_exl <= 1'b1;
        end else if (do_eret) begin
            st_exl <= 1'b0;
        end else if (wr_status) begin
            st_im  <= mem_wdata[15:8];
            st_exl <= mem_wdata[cp0_pkg::st_exl];
            st_ie  <= mem_wdata[cp0_pkg::st_ie];
        end
    end

    // BD and EPC only follow the first exception of a nest
    always_ff @(posedge clk) begin
        if (!rst) begin
            ca_bd      <= 1'b0;
            ca_exccode <= '0;
        end else if (take_exc) begin
            ca_exccode <= mem_exccode;
            if (!st_exl) begin
                ca_bd <= mem_bd;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_exc && !st_exl) begin
            epc <= mem_bd ? mem_pc - 32'd4 : mem_pc;   // Restart at the branch
        end else if (wr_epc) begin
            epc <= mem_wdata;
        end
    end

    // Compare write acknowledges the timer
    always_ff @(posedge clk) begin
        if (!rst) begin
            ca_ti <= 1'b0;
        end else if (wr_compare) begin
            ca_ti <= 1'b0;
        end else if (count == compare) begin
            ca_ti <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ca_ip_hw <= '0;
            ca_ip_sw <= '0;
        end else begin
            ca_ip_hw <= {ext_int_in[5] | ca_ti, ext_int_in[4:0]};   // Sampled each clock
            if (wr_cause) begin
                ca_ip_sw <= mem_wdata[9:8];
            end
        end
    end

    always_comb begin
        status_word                  = '0;
        status_word[cp0_pkg::st_bev] = 1'b1;   // Fixed boot vectors
        status_word[15:8]            = st_im;
        status_word[cp0_pkg::st_exl] = st_exl;
        status_word[cp0_pkg::st_ie]  = st_ie;
    end

    always_comb begin
        cause_word                 = '0;
        cause_word[cp0_pkg::ca_bd] = ca_bd;
        cause_word[cp0_pkg::ca_ti] = ca_ti;
        cause_word[15:10]          = ca_ip_hw;
        cause_word[9:8]            = ca_ip_sw;
        cause_word[6:2]            = ca_exccode;
    end

    assign interrupt = (|(cause_word[15:8] & st_im)) && st_ie && !st_exl;

    // MFC0 read port
    always_comb begin
        case (mem_cp0_addr)
            cp0_pkg::badvaddr_idx: rdata = badvaddr;
            cp0_pkg::count_idx:    rdata = count;
            cp0_pkg::compare_idx:  rdata = compare;
            cp0_pkg::status_idx:   rdata = status_word;
            cp0_pkg::cause_idx:    rdata = cause_word;
            cp0_pkg::epc_idx:      rdata = epc;
            default:               rdata = '0;
        endcase
    end

endmodule

/* rtl/exc_redirect.sv */
`timescale 1ns/1ps

module exc_redirect (
    input  logic            mem_valid,
    input  cp0_pkg::op_t    mem_op,
    input  logic            mem_exc,
    input  cp0_pkg::word_t  epc,
    output logic            redirect,
    output cp0_pkg::word_t  redirect_pc
);

    logic is_eret;

    assign is_eret = (mem_op == cp0_pkg::op_eret);

    // Fetch restarts on any committed exception or return
    assign redirect = mem_valid && (mem_exc || is_eret);

    // An interrupt tagged on an ERET still goes to the handler
    always_comb begin
        if (mem_exc) begin
            redirect_pc = cp0_pkg::exc_vector;
        end else begin
            redirect_pc = epc;
        end
    end

endmodule

/* rtl/cp0_subsys_top.sv */
`timescale 1ns/1ps

module cp0_subsys_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            ex_valid,
    input  cp0_pkg::op_t    ex_op,
    input  cp0_pkg::word_t  ex_pc,
    input  logic            ex_bd,
    input  cp0_pkg::word_t  ex_mem_addr,
    input  logic [7:0]      ex_cp0_addr,
    input  cp0_pkg::word_t  ex_wdata,
    input  logic [5:0]      ext_int_in,
    output cp0_pkg::word_t  cp0_rdata,
    output logic            redirect,
    output cp0_pkg::word_t  redirect_pc,
    output logic            interrupt
);

    logic           det_exc;
    logic [4:0]     det_exccode;
    cp0_pkg::word_t det_badvaddr;

    logic           mem_valid;
    cp0_pkg::op_t   mem_op;
    cp0_pkg::word_t mem_pc;
    logic           mem_bd;
    logic [7:0]     mem_cp0_addr;
    cp0_pkg::word_t mem_wdata;
    logic           mem_exc;
    logic [4:0]     mem_exccode;
    cp0_pkg::word_t mem_badvaddr;
    cp0_pkg::word_t epc;

    exc_detect u_detect (
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_pc        (ex_pc),
        .ex_mem_addr  (ex_mem_addr),
        .interrupt    (interrupt),
        .det_exc      (det_exc),
        .det_exccode  (det_exccode),
        .det_badvaddr (det_badvaddr)
    );

    exc_stage_reg u_stage (
        .clk          (clk),
        .rst          (rst),
        .flush        (redirect),   // Squash behind a redirect
        .ex_valid     (ex_valid),
        .ex_op        (ex_op),
        .ex_pc        (ex_pc),
        .ex_bd        (ex_bd),
        .ex_cp0_addr  (ex_cp0_addr),
        .ex_wdata     (ex_wdata),
        .det_exc      (det_exc),
        .det_exccode  (det_exccode),
        .det_badvaddr (det_badvaddr),
        .mem_valid    (mem_valid),
        .mem_op       (mem_op),
        .mem_pc       (mem_pc),
        .mem_bd       (mem_bd),
        .mem_cp0_addr (mem_cp0_addr),
        .mem_wdata    (mem_wdata),
        .mem_exc      (mem_exc),
        .mem_exccode  (mem_exccode),
        .mem_badvaddr (mem_badvaddr)
    );

    cp0_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .mem_valid    (mem_valid),
        .mem_op       (mem_op),
        .mem_pc       (mem_pc),
        .mem_bd       (mem_bd),
        .mem_cp0_addr (mem_cp0_addr),
        .mem_wdata    (mem_wdata),
        .mem_exc      (mem_exc),
        .mem_exccode  (mem_exccode),
        .mem_badvaddr (mem_badvaddr),
        .ext_int_in   (ext_int_in),
        .rdata        (cp0_rdata),
        .epc          (epc),
        .interrupt    (interrupt)
    );

    exc_redirect u_redirect (
        .mem_valid   (mem_valid),
        .mem_op      (mem_op),
        .mem_exc     (mem_exc),
        .epc         (epc),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

/* tb/cp0_tb.sv */
`timescale 1ns/1ps

module cp0_tb;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    localparam int num_tests    = 6;
    localparam int test_cycles  = 200;

    logic           clk;
    logic           rst;
    logic           ex_valid;
    cp0_pkg::op_t   ex_op;
    cp0_pkg::word_t ex_pc;
    logic           ex_bd;
    cp0_pkg::word_t ex_mem_addr;
    logic [7:0]     ex_cp0_addr;
    cp0_pkg::word_t ex_wdata;
    logic [5:0]     ext_int_in;
    cp0_pkg::word_t cp0_rdata;
    logic           redirect;
    cp0_pkg::word_t redirect_pc;
    logic           interrupt;

    logic [15:0]    lfsr = 16'd12;
    int             errors;
    int             test_start;
    int             tests_run;

    cp0_subsys_top UUT (
        .clk         (clk),
        .rst         (rst),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_pc       (ex_pc),
        .ex_bd       (ex_bd),
        .ex_mem_addr (ex_mem_addr),
        .ex_cp0_addr (ex_cp0_addr),
        .ex_wdata    (ex_wdata),
        .ext_int_in  (ext_int_in),
        .cp0_rdata   (cp0_rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .interrupt   (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output cp0_pkg::word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};   // One step per bit
        end
    endtask

    task automatic check_word(input string name, input cp0_pkg::word_t got,
                              input cp0_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Returns with the instruction in the memory stage and execute idle
    task automatic issue(input cp0_pkg::op_t op, input cp0_pkg::word_t pc, input logic bd,
                         input cp0_pkg::word_t addr, input logic [7:0] sel,
                         input cp0_pkg::word_t data);
        ex_valid    = 1'b1;
        ex_op       = op;
        ex_pc       = pc;
        ex_bd       = bd;
        ex_mem_addr = addr;
        ex_cp0_addr = sel;
        ex_wdata    = data;
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
        ex_op    = cp0_pkg::op_none;
    endtask

    task automatic idle();
        ex_valid = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic read_cp0(input logic [7:0] sel, output cp0_pkg::word_t v);
        issue(cp0_pkg::op_mfc0, '0, 1'b0, '0, sel, '0);
        v = cp0_rdata;   // Valid while the MFC0 sits in memory
    endtask

    task automatic write_cp0(input logic [7:0] sel, input cp0_pkg::word_t data);
        issue(cp0_pkg::op_mtc0, '0, 1'b0, '0, sel, data);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d check(s) failed", name, errors - test_start);
        end
        test_start = errors;
    endtask

    task automatic reset_and_readback();
        cp0_pkg::word_t v;
        cp0_pkg::word_t w_cmp;
        cp0_pkg::word_t w_epc;
        cp0_pkg::word_t w_st;
        check_bit("interrupt", interrupt, 1'b0);
        check_bit("redirect", redirect, 1'b0);
        read_cp0(cp0_pkg::status_idx, v);
        check_word("Status", v, 32'h0040_0000);   // Only BEV after reset
        random_word(w_cmp);
        random_word(w_epc);
        random_word(w_st);
        w_st[cp0_pkg::st_bev] = 1'b0;   // Attempt to clear BEV
        write_cp0(cp0_pkg::compare_idx, w_cmp);
        write_cp0(cp0_pkg::epc_idx, w_epc);
        write_cp0(cp0_pkg::status_idx, w_st);
        read_cp0(cp0_pkg::compare_idx, v);
        check_word("Compare", v, w_cmp);
        read_cp0(cp0_pkg::epc_idx, v);
        check_word("EPC", v, w_epc);
        read_cp0(cp0_pkg::status_idx, v);
        check_word("Status", v, (w_st & 32'h0000_FF03) | 32'h0040_0000);
        write_cp0(cp0_pkg::status_idx, '0);
        report_test("MTC0/MFC0 round trip");
    endtask

    task automatic sync_case(input cp0_pkg::op_t op, input logic [4:0] code);
        cp0_pkg::word_t pc;
        cp0_pkg::word_t addr;
        cp0_pkg::word_t v;
        random_word(pc);
        random_word(addr);
        pc[1:0]   = 2'b00;
        addr[1:0] = 2'b10;   // Faults only for lw and sw
        issue(op, pc, 1'b0, addr, 8'h00, '0);
        check_bit("redirect", redirect, 1'b1);
        check_word("redirect_pc", redirect_pc, cp0_pkg::exc_vector);
        idle();
        read_cp0(cp0_pkg::cause_idx, v);
        check_word("Cause.ExcCode", (v >> 2) & 32'h1F, {27'd0, code});
        if (op == cp0_pkg::op_lw || op == cp0_pkg::op_sw) begin
            read_cp0(cp0_pkg::badvaddr_idx, v);
            check_word("BadVAddr", v, addr);
        end
        issue(cp0_pkg::op_eret, '0, 1'b0, '0, 8'h00, '0);
        check_bit("redirect", redirect, 1'b1);
        check_word("redirect_pc", redirect_pc, pc);
        idle();
    endtask

    task automatic sync_exceptions();
        sync_case(cp0_pkg::op_syscall, cp0_pkg::exc_sys);
        sync_case(cp0_pkg::op_break, cp0_pkg::exc_bp);
        sync_case(cp0_pkg::op_rsvd, cp0_pkg::exc_ri);
        sync_case(cp0_pkg::op_lw, cp0_pkg::exc_adel);
        sync_case(cp0_pkg::op_sw, cp0_pkg::exc_ades);
        report_test("Synchronous exceptions");
    endtask

    task automatic delay_slot_epc();
        cp0_pkg::word_t p1;
        cp0_pkg::word_t p2;
        cp0_pkg::word_t p3;
        cp0_pkg::word_t v;
        random_word(p1);
        random_word(p2);
        random_word(p3);
        p1[1:0] = 2'b00;
        p2[1:0] = 2'b00;
        p3[1:0] = 2'b00;
        issue(cp0_pkg::op_syscall, p1, 1'b0, '0, 8'h00, '0);
        idle();
        read_cp0(cp0_pkg::epc_idx, v);
        check_word("EPC", v, p1);
        read_cp0(cp0_pkg::cause_idx, v);
        check_bit("Cause.BD", v[cp0_pkg::ca_bd], 1'b0);
        issue(cp0_pkg::op_eret, '0, 1'b0, '0, 8'h00, '0);
        idle();
        issue(cp0_pkg::op_break, p2, 1'b1, '0, 8'h00, '0);   // Sits in a delay slot
        idle();
        read_cp0(cp0_pkg::epc_idx, v);
        check_word("EPC", v, p2 - 32'd4);
        read_cp0(cp0_pkg::cause_idx, v);
        check_bit("Cause.BD", v[cp0_pkg::ca_bd], 1'b1);
        // Nested fault with EXL set
        issue(cp0_pkg::op_syscall, p3, 1'b0, '0, 8'h00, '0);
        idle();
        read_cp0(cp0_pkg::epc_idx, v);
        check_word("EPC", v, p2 - 32'd4);
        read_cp0(cp0_pkg::cause_idx, v);
        check_bit("Cause.BD", v[cp0_pkg::ca_bd], 1'b1);
        issue(cp0_pkg::op_eret, '0, 1'b0, '0, 8'h00, '0);
        check_word("redirect_pc", redirect_pc, p2 - 32'd4);
        idle();
        read_cp0(cp0_pkg::status_idx, v);
        check_bit("Status.EXL", v[cp0_pkg::st_exl], 1'b0);
        report_test("EPC and delay slot");
    endtask

    task automatic squash_after_fault();
        cp0_pkg::word_t pc;
        cp0_pkg::word_t w;
        cp0_pkg::word_t v;
        random_word(pc);
        random_word(w);
        pc[1:0] = 2'b00;
        issue(cp0_pkg::op_syscall, pc, 1'b0, '0, 8'h00, '0);
        check_bit("redirect", redirect, 1'b1);
        issue(cp0_pkg::op_mtc0, '0, 1'b0, '0, cp0_pkg::epc_idx, w);   // Younger, dropped
        check_bit("redirect", redirect, 1'b0);
        read_cp0(cp0_pkg::epc_idx, v);
        check_word("EPC", v, pc);
        issue(cp0_pkg::op_eret, '0, 1'b0, '0, 8'h00, '0);
        idle();
        report_test("Squash behind redirect");
    endtask

    task automatic interrupt_lines();
        cp0_pkg::word_t w;
        cp0_pkg::word_t pc;
        cp0_pkg::word_t v;
        cp0_pkg::word_t im;
        int             k;
        random_word(w);
        random_word(pc);
        pc[1:0] = 2'b00;
        k  = w % 6;
        im = 32'h1 << (10 + k);   // IM bit of line k
        write_cp0(cp0_pkg::status_idx, im | 32'h1);
        idle();
        ext_int_in[k] = 1'b1;
        check_bit("interrupt", interrupt, 1'b0);
        idle();
        check_bit("interrupt", interrupt, 1'b1);
        issue(cp0_pkg::op_none, pc, 1'b0, '0, 8'h00, '0);
        check_bit("redirect", redirect, 1'b1);
        check_word("redirect_pc", redirect_pc, cp0_pkg::exc_vector);
        idle();
        ext_int_in = '0;
        read_cp0(cp0_pkg::cause_idx, v);
        check_word("Cause.ExcCode", (v >> 2) & 32'h1F, {27'd0, cp0_pkg::exc_int});
        check_bit("interrupt", interrupt, 1'b0);
        issue(cp0_pkg::op_eret, '0, 1'b0, '0, 8'h00, '0);
        check_word("redirect_pc", redirect_pc, pc);
        idle();
        // Masked line, then IE clear, then EXL set
        write_cp0(cp0_pkg::status_idx, (32'hFF00 & ~im) | 32'h1);
        idle();
        ext_int_in[k] = 1'b1;
        idle();
        idle();
        check_bit("interrupt", interrupt, 1'b0);
        write_cp0(cp0_pkg::status_idx, im);
        idle();
        idle();
        check_bit("interrupt", interrupt, 1'b0);
        write_cp0(cp0_pkg::status_idx, im | 32'h3);
        idle();
        check_bit("interrupt", interrupt, 1'b0);
        ext_int_in = '0;
        idle();
        idle();
        // Software line IP0
        write_cp0(cp0_pkg::status_idx, 32'h0101);
        write_cp0(cp0_pkg::cause_idx, 32'h0100);
        idle();
        check_bit("interrupt", interrupt, 1'b1);
        issue(cp0_pkg::op_syscall, pc, 1'b0, '0, 8'h00, '0);   // Interrupt outranks syscall
        check_bit("redirect", redirect, 1'b1);
        idle();
        read_cp0(cp0_pkg::cause_idx, v);
        check_word("Cause.ExcCode", (v >> 2) & 32'h1F, {27'd0, cp0_pkg::exc_int});
        write_cp0(cp0_pkg::cause_idx, '0);
        write_cp0(cp0_pkg::status_idx, '0);
        report_test("External and software interrupts");
    endtask

    task automatic timer_interrupt();
        cp0_pkg::word_t v;
        int             n;
        write_cp0(cp0_pkg::compare_idx, 32'd10);
        write_cp0(cp0_pkg::count_idx, 32'd0);
        write_cp0(cp0_pkg::status_idx, 32'h8001);   // IM7 and IE
        n = 0;
        while (!interrupt && n < 40) begin
            idle();
            n++;
        end
        if (!interrupt) begin
            $display("Timer interrupt did not rise within 40 cycles");
            errors++;
        end
        read_cp0(cp0_pkg::cause_idx, v);   // Carries the interrupt as well
        check_bit("Cause.TI", v[cp0_pkg::ca_ti], 1'b1);
        check_bit("redirect", redirect, 1'b1);
        idle();
        write_cp0(cp0_pkg::compare_idx, 32'd1000);
        idle();
        write_cp0(cp0_pkg::status_idx, 32'h8001);
        idle();
        check_bit("interrupt", interrupt, 1'b0);
        read_cp0(cp0_pkg::cause_idx, v);
        check_bit("Cause.TI", v[cp0_pkg::ca_ti], 1'b0);
        report_test("Count/Compare timer");
    endtask

    initial begin
        rst         = 1'b0;
        ex_valid    = 1'b0;
        ex_op       = cp0_pkg::op_none;
        ex_pc       = '0;
        ex_bd       = 1'b0;
        ex_mem_addr = '0;
        ex_cp0_addr = '0;
        ex_wdata    = '0;
        ext_int_in  = '0;
        errors      = 0;
        test_start  = 0;
        tests_run   = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b1;
        reset_and_readback();
        sync_exceptions();
        delay_slot_epc();
        squash_after_fault();
        interrupt_lines();
        timer_interrupt();
        $display("Tests run: %0d, failing checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Budget of test_cycles per test plus reset
    initial begin
        #((reset_cycles + num_tests * test_cycles) * clk_period);
        $display("Watchdog expired before the tests completed");
        $display("Test failures found");
        $finish;
    end

endmodule

/* all.f */
rtl/cp0_pkg.sv
rtl/exc_detect.sv
rtl/exc_stage_reg.sv
rtl/cp0_regs.sv
rtl/exc_redirect.sv
rtl/cp0_subsys_top.sv
tb/cp0_tb.sv
